/* sig_engine.f */
source/sig_pkg.sv
source/stream_tracker.sv
source/sig_dfa.sv
source/sig_rule_ctx.sv
source/sig_engine.sv
sim/sig_engine_tb.sv

/* Makefile */
# Verilator build and run of the signature engine testbench

VERILATOR ?= verilator
TOP       ?= sig_engine_tb
FILELIST  ?= sig_engine.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= No errors
VFLAGS    ?= --binary --timing

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# Pass only if the testbench printed its pass line
run: compile
	./$(BIN) | tee $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* sim/sig_engine_tb.sv */
`timescale 1ns/100ps

module sig_engine_tb;

   localparam int NR = 3;
   localparam int CW = 16;
   localparam int RESET_TIMEOUT = 10;

   logic           clk;
   logic           rst_n;
   logic           sop;
   logic [5:0]     stream_id;
   logic [7:0]     char_in;
   logic           char_vld;
   logic           eop;
   logic [NR-1:0]  rule_enable;
   logic [NR*CW-1:0] count;
   logic [NR-1:0]  fired;

   // POP3 signatures in rule order
   string pats [NR] = '{"USER ", "PASS ", "RETR"};

   // Reference model with one saved DFA state per stream and rule
   int            model_state [64][NR];
   bit            model_seen [64];
   logic [CW-1:0] model_count [NR];

   string       cur_test;
   int          test_errors;
   int          errors;
   int          tests_run;
   int          tests_failed;
   logic [31:0] lfsr;

   sig_engine sig_engine_i (.*);

   initial
   begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   // Galois LFSR stepped once per bit handed out
   function automatic bit lfsr_bit();
      bit out;
      out = lfsr[0];
      lfsr = lfsr >> 1;
      if (out)
         lfsr = lfsr ^ 32'h80200003;
      return out;
   endfunction

   function automatic int rand_bits(input int n);
      int v;
      v = 0;
      for (int i = 0; i < n; i++)
         v = (v << 1) | int'(lfsr_bit());
      return v;
   endfunction

   // Longest k up to limit where the last k bytes of seq start rule r
   function automatic int tail_match(input byte seq [0:15], input int n, input int r,
                                     input int limit);
      int best;
      bit same;
      best = 0;
      for (int k = 1; (k <= limit) && (k <= n); k++)
      begin
         same = 1'b1;
         for (int j = 0; j < k; j++)
            if (seq[n-k+j] != pats[r][j])
               same = 1'b0;
         if (same)
            best = k;
      end
      return best;
   endfunction

   // Brute force next state from the matched prefix plus the folded byte
   function automatic int dfa_next(input int r, input int st, input byte c, output bit acc);
      byte seq [0:15];
      int len;
      int k;
      len = pats[r].len();
      for (int i = 0; i < 16; i++)
         seq[i] = (i < st) ? pats[r][i] : 8'h00;
      seq[st] = ((c >= "a") && (c <= "z")) ? c - 8'h20 : c;
      k = tail_match(seq, st + 1, r, len);
      acc = (k == len);
      // Full match keeps its longest proper border for overlaps
      if (acc)
         k = tail_match(seq, st + 1, r, len - 1);
      return k;
   endfunction

   task automatic cycles(input int n);
      for (int i = 0; i < n; i++)
         @(negedge clk);
   endtask

   task automatic check_value(input string what, input logic [31:0] exp,
                              input logic [31:0] act);
      if (exp !== act)
      begin
         $display("** Error %s: %s expected %0h actual %0h", cur_test, what, exp, act);
         test_errors++;
      end
   endtask

   task automatic start_test(input string name);
      cur_test = name;
      test_errors = 0;
   endtask

   task automatic end_test();
      tests_run++;
      errors += test_errors;
      if (test_errors == 0)
         $display("PASS %s", cur_test);
      else
      begin
         $display("FAIL %s: %0d mismatches", cur_test, test_errors);
         tests_failed++;
      end
   endtask

   // Reset for 3 cycles and let the model forget every stream
   task automatic apply_reset();
      int waited;
      rst_n = 1'b0;
      sop = 1'b0;
      char_vld = 1'b0;
      eop = 1'b0;
      cycles(3);
      rst_n = 1'b1;
      for (int r = 0; r < NR; r++)
         model_count[r] = '0;
      for (int s = 0; s < 64; s++)
         model_seen[s] = 1'b0;
      waited = 0;
      while ((count !== '0) && (waited < RESET_TIMEOUT))
      begin
         @(negedge clk);
         waited++;
      end
      if (count !== '0)
      begin
         $display("%s: counts still not zero %0d cycles after reset", cur_test, waited);
         test_errors++;
      end
   endtask

   // One packet of sop then bytes then eop with the model following along
   task automatic send_packet(input int stream, input string data,
                              input logic [NR-1:0] mask, input bit gaps);
      int st [NR];
      bit hit [NR];
      bit acc;
      bit was_new;
      was_new = !model_seen[stream];
      for (int r = 0; r < NR; r++)
      begin
         st[r] = was_new ? 0 : model_state[stream][r];
         hit[r] = 1'b0;
      end
      sop = 1'b1;
      stream_id = 6'(stream);
      @(negedge clk);
      sop = 1'b0;
      // DFA restore completes before the first byte
      cycles(2);
      for (int i = 0; i < data.len(); i++)
      begin
         char_in = data[i];
         char_vld = 1'b1;
         for (int r = 0; r < NR; r++)
         begin
            st[r] = dfa_next(r, st[r], data[i], acc);
            if (acc)
               hit[r] = 1'b1;
         end
         @(negedge clk);
         char_vld = 1'b0;
         if (gaps && lfsr_bit())
            @(negedge clk);
      end
      @(negedge clk);
      for (int r = 0; r < NR; r++)
         check_value($sformatf("fired[%0d] before eop", r), 32'(hit[r]), 32'(fired[r]));
      eop = 1'b1;
      rule_enable = mask;
      @(negedge clk);
      eop = 1'b0;
      // Disabled rules keep their saved state
      model_seen[stream] = 1'b1;
      for (int r = 0; r < NR; r++)
      begin
         if (mask[r])
         begin
            model_count[r] = model_count[r] + CW'(hit[r]);
            model_state[stream][r] = st[r];
         end
         else if (was_new)
            // Nothing saved yet so the next packet starts from zero
            model_state[stream][r] = 0;
         check_value($sformatf("fired[%0d] after eop", r), 32'(hit[r] && mask[r]),
                     32'(fired[r]));
      end
   endtask

   task automatic check_counts();
      @(negedge clk);
      for (int r = 0; r < NR; r++)
         check_value($sformatf("count[%0d]", r), 32'(model_count[r]),
                     32'(count[r*CW +: CW]));
   endtask

   task automatic single_packet();
      start_test("single_packet");
      send_packet(1, "xxUSER yy", 3'b111, 1'b0);
      check_counts();
      end_test();
   endtask

   // Signature split over two packets of stream 5
   task automatic split_stream();
      start_test("split_stream");
      send_packet(5, "US", 3'b111, 1'b0);
      check_counts();
      send_packet(9, "ER ", 3'b111, 1'b0);
      check_counts();
      send_packet(5, "ER ", 3'b111, 1'b1);
      check_counts();
      end_test();
   endtask

   task automatic case_and_overlap();
      start_test("case_and_overlap");
      send_packet(30, "user ", 3'b111, 1'b0);
      check_counts();
      send_packet(31, "PAPASS ", 3'b111, 1'b0);
      check_counts();
      send_packet(32, "USER USER ", 3'b111, 1'b0);
      check_counts();
      end_test();
   endtask

   // USER disabled at eop keeps its saved state at zero
   task automatic disabled_rule();
      start_test("disabled_rule");
      send_packet(12, "xx", 3'b111, 1'b0);
      check_counts();
      send_packet(12, "USER ", 3'b110, 1'b0);
      check_counts();
      send_packet(12, "US", 3'b110, 1'b0);
      check_counts();
      send_packet(12, "ER ", 3'b111, 1'b0);
      check_counts();
      end_test();
   endtask

   task automatic reset_clears();
      start_test("reset_clears");
      send_packet(20, "US", 3'b111, 1'b0);
      apply_reset();
      check_counts();
      send_packet(20, "ER ", 3'b111, 1'b0);
      check_counts();
      end_test();
   endtask

   task automatic random_packets();
      string alphabet;
      string data;
      int stream;
      int len;
      int k;
      logic [NR-1:0] mask;
      alphabet = "USERPAT ";
      start_test("random_packets");
      for (int p = 0; p < 200; p++)
      begin
         stream = (rand_bits(1) == 1) ? 40 + rand_bits(1) : 2 + rand_bits(1);
         len = rand_bits(4);
         data = "";
         for (int i = 0; i < len; i++)
         begin
            k = rand_bits(3);
            data = {data, alphabet.substr(k, k)};
         end
         mask = NR'(rand_bits(NR));
         send_packet(stream, data, mask, 1'b1);
         check_counts();
      end
      end_test();
   endtask

   initial
   begin
      rst_n = 1'b1;
      sop = 1'b0;
      stream_id = '0;
      char_in = '0;
      char_vld = 1'b0;
      eop = 1'b0;
      rule_enable = '1;
      lfsr = 32'hec49;
      errors = 0;
      tests_run = 0;
      tests_failed = 0;
      @(negedge clk);
      start_test("power_on_reset");
      apply_reset();
      end_test();
      single_packet();
      split_stream();
      case_and_overlap();
      disabled_rule();
      reset_clears();
      random_packets();
      $display("Summary: %0d tests, %0d failed, %0d mismatches", tests_run, tests_failed,
               errors);
      if (errors == 0)
         $display("No errors");
      else
         $display("Errors found");
      $finish;
   end

endmodule

/* source/sig_engine.sv */
`timescale 1ns/100ps

module sig_engine #(
   parameter int STREAM_W = sig_pkg::STREAM_W,
   parameter int NUM_RULES = sig_pkg::NUM_RULES,
   parameter logic [0:NUM_RULES-1][sig_pkg::MAX_PAT*8-1:0] RULE_PAT = sig_pkg::rule_pat,
   parameter logic [0:NUM_RULES-1][sig_pkg::STATE_W-1:0] RULE_LEN = sig_pkg::rule_len
) (
   input  logic                                  clk,
   input  logic                                  rst_n,
   input  logic                                  sop,
   input  logic [STREAM_W-1:0]                   stream_id,
   input  logic [7:0]                            char_in,
   input  logic                                  char_vld,
   input  logic                                  eop,
   input  logic [NUM_RULES-1:0]                  rule_enable,
   output logic [NUM_RULES*sig_pkg::COUNT_W-1:0] count,
   output logic [NUM_RULES-1:0]                  fired
);

   import sig_pkg::*;

   // Shared packet context from the tracker
   logic                load_state;
   logic                new_stream;
   logic [STREAM_W-1:0] cur_stream;

   stream_tracker #(
      .STREAM_W (STREAM_W)
   ) stream_tracker_i (
      .clk        (clk),
      .rst_n      (rst_n),
      .sop        (sop),
      .stream_id  (stream_id),
      .eop        (eop),
      .load_state (load_state),
      .new_stream (new_stream),
      .cur_stream (cur_stream)
   );

   // One context per signature, rule r owns count slice r
   for (genvar r = 0; r < NUM_RULES; r++)
   begin : g_rule
      sig_rule_ctx #(
         .STREAM_W (STREAM_W),
         .PATTERN  (RULE_PAT[r]),
         .PAT_LEN  (int'(RULE_LEN[r]))
      ) sig_rule_ctx_i (
         .clk        (clk),
         .rst_n      (rst_n),
         .char_in    (char_in),
         .char_vld   (char_vld),
         .load_state (load_state),
         .new_stream (new_stream),
         .cur_stream (cur_stream),
         .eop        (eop),
         .enable     (rule_enable[r]),
         .count      (count[r*COUNT_W +: COUNT_W]),
         .fired      (fired[r])
      );
   end

endmodule

/* source/sig_rule_ctx.sv */
`timescale 1ns/100ps

module sig_rule_ctx #(
   parameter int STREAM_W = sig_pkg::STREAM_W,
   parameter logic [sig_pkg::MAX_PAT*8-1:0] PATTERN = sig_pkg::rule_pat[0],
   parameter int PAT_LEN = 5
) (
   input  logic                        clk,
   input  logic                        rst_n,
   input  logic [7:0]                  char_in,
   input  logic                        char_vld,
   input  logic                        load_state,
   input  logic                        new_stream,
   input  logic [STREAM_W-1:0]         cur_stream,
   input  logic                        eop,
   input  logic                        enable,
   output logic [sig_pkg::COUNT_W-1:0] count,
   output logic                        fired
);

   import sig_pkg::*;

   // Saved DFA state per stream
   logic [STATE_W-1:0] state_mem [0:(1<<STREAM_W)-1];

   // Restore path into the DFA
   logic [STATE_W-1:0] state_in;
   logic               state_in_vld;

   // DFA outputs
   logic [STATE_W-1:0] state_out;
   logic               accept_out;

   // Set by any match in the current packet and committed at eop
   logic               spec_match;

   // Restore pulse one cycle after load_state
   always_ff @(posedge clk)
   begin
      if (!rst_n)
         state_in_vld <= 1'b0;
      else
         state_in_vld <= load_state;
   end

   // A stream never seen restores zero
   always_ff @(posedge clk)
   begin
      if (load_state)
         state_in <= new_stream ? '0 : state_mem[cur_stream];
   end

   // Save the stream's state only when the rule is enabled at eop
   // The first packet of a stream still leaves a zero entry behind
   always_ff @(posedge clk)
   begin
      if (eop && enable)
         state_mem[cur_stream] <= state_out;
      else if (eop && new_stream)
         state_mem[cur_stream] <= '0;
   end

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         count <= '0;
         spec_match <= 1'b0;
      end
      else
      begin
         // Fresh packet drops the previous flag
         if (load_state)
            spec_match <= 1'b0;

         // Any match in the packet arms the flag
         if (accept_out)
            spec_match <= 1'b1;

         if (eop)
         begin
            if (enable)
               // At most one count per packet
               count <= count + COUNT_W'(spec_match);
            else
               // Disabled rule throws the match away
               spec_match <= 1'b0;
         end
      end
   end

   assign fired = spec_match;

   sig_dfa #(
      .PATTERN (PATTERN),
      .PAT_LEN (PAT_LEN)
   ) sig_dfa_i (
      .clk          (clk),
      .rst_n        (rst_n),
      .char_in      (char_in),
      .char_vld     (char_vld),
      .state_in     (state_in),
      .state_in_vld (state_in_vld),
      .state_out    (state_out),
      .accept_out   (accept_out)
   );

endmodule

/* source/sig_dfa.sv */
`timescale 1ns/100ps

module sig_dfa #(
   parameter logic [sig_pkg::MAX_PAT*8-1:0] PATTERN = sig_pkg::rule_pat[0],
   parameter int PAT_LEN = 5
) (
   input  logic                      clk,
   input  logic                      rst_n,
   input  logic [7:0]                char_in,
   input  logic                      char_vld,
   input  logic [sig_pkg::STATE_W-1:0] state_in,
   input  logic                      state_in_vld,
   output logic [sig_pkg::STATE_W-1:0] state_out,
   output logic                      accept_out
);

   import sig_pkg::*;

   // Byte idx of the signature, 0 is the first character
   function automatic logic [7:0] pat_byte(input int idx);
      logic [7:0] b;
      b = 8'h00;
      if ((idx >= 0) && (idx < MAX_PAT))
         b = PATTERN[(MAX_PAT-1-idx)*8 +: 8];
      return b;
   endfunction

   // Failure links: longest proper prefix that is also a suffix
   // Entry k belongs to a matched prefix of length k
   function automatic logic [MAX_PAT:0][STATE_W-1:0] calc_fail();
      logic [MAX_PAT:0][STATE_W-1:0] f;
      int k;
      f = '0;
      k = 0;
      for (int i = 1; i < PAT_LEN; i++)
      begin
         // Shrink the candidate border until the next byte extends it
         while ((k > 0) && (pat_byte(i) != pat_byte(k)))
            k = int'(f[k]);
         if (pat_byte(i) == pat_byte(k))
            k++;
         f[i+1] = STATE_W'(k);
      end
      return f;
   endfunction

   localparam logic [MAX_PAT:0][STATE_W-1:0] FAIL = calc_fail();

   logic [STATE_W-1:0] state_q;
   logic [STATE_W-1:0] next_state;
   logic [7:0]         char_up;
   logic               hit;

   // Fold lower case letters onto upper case
   assign char_up = ((char_in >= 8'h61) && (char_in <= 8'h7a)) ? (char_in - 8'h20) : char_in;

   // Next prefix length for the current byte
   always_comb
   begin
      logic [STATE_W-1:0] cand;
      logic               done;
      cand = state_q;
      done = 1'b0;
      next_state = '0;
      // A failure chain is never longer than the current state
      for (int i = 0; i <= MAX_PAT; i++)
      begin
         if (!done)
         begin
            if (char_up == pat_byte(int'(cand)))
            begin
               // Byte extends this prefix
               next_state = cand + 1'b1;
               done = 1'b1;
            end
            else if (cand == '0)
            begin
               // Nothing left to fall back on
               next_state = '0;
               done = 1'b1;
            end
            else
               cand = FAIL[cand];
         end
      end
   end

   // Full signature seen
   assign hit = (next_state == STATE_W'(PAT_LEN));

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         state_q <= '0;
         accept_out <= 1'b0;
      end
      else if (state_in_vld)
      begin
         // Restore wins over any byte in the same cycle
         state_q <= state_in;
         accept_out <= 1'b0;
      end
      else if (char_vld)
      begin
         // On a full match continue from its border so overlaps still count
         state_q <= hit ? FAIL[PAT_LEN] : next_state;
         accept_out <= hit;
      end
      else
         accept_out <= 1'b0;
   end

   assign state_out = state_q;

endmodule

/* source/stream_tracker.sv */
`timescale 1ns/100ps

module stream_tracker #(
   parameter int STREAM_W = sig_pkg::STREAM_W
) (
   input  logic                clk,
   input  logic                rst_n,
   input  logic                sop,
   input  logic [STREAM_W-1:0] stream_id,
   input  logic                eop,
   output logic                load_state,
   output logic                new_stream,
   output logic [STREAM_W-1:0] cur_stream
);

   import sig_pkg::*;

   tracker_state_t state;

   // One bit per stream, set once a packet of it has ended
   logic [(1<<STREAM_W)-1:0] seen;

   // Packet FSM, seen bitmap and load pulse
   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         state <= IDLE;
         seen <= '0;
         load_state <= 1'b0;
      end
      else
      begin
         load_state <= 1'b0;
         if (sop)
         begin
            // Also taken inside a packet, a new sop restarts it
            load_state <= 1'b1;
            state <= IN_PKT;
         end
         else if (eop && (state == IN_PKT))
         begin
            // Stream now has saved state in every enabled rule
            seen[cur_stream] <= 1'b1;
            state <= IDLE;
         end
      end
   end

   // Stream id and its new flag for the whole packet
   always_ff @(posedge clk)
   begin
      if (sop)
      begin
         cur_stream <= stream_id;
         new_stream <= ~seen[stream_id];
      end
   end

endmodule

/* source/sig_pkg.sv */
package sig_pkg;

   // Stream id width and the number of streams it can address
   localparam int STREAM_W = 6;
   localparam int NUM_STREAMS = 1 << STREAM_W;

   // DFA state holds the matched prefix length, up to 15 bytes
   localparam int STATE_W = 4;

   // Per-rule match counter width
   localparam int COUNT_W = 16;

   // Number of signatures matched in parallel
   localparam int NUM_RULES = 3;

   // Longest signature in bytes
   localparam int MAX_PAT = 8;

   // Signature table, first character in the top byte, zero padded
   localparam logic [0:NUM_RULES-1][MAX_PAT*8-1:0] rule_pat = '{
      {"USER ", 24'h0},
      {"PASS ", 24'h0},
      {"RETR", 32'h0}
   };

   // Signature lengths, one per table entry
   localparam logic [0:NUM_RULES-1][STATE_W-1:0] rule_len = '{
      4'd5,
      4'd5,
      4'd4
   };

   // Packet tracker FSM
   typedef enum logic {
      IDLE,
      IN_PKT
   } tracker_state_t;

endpackage
